// ==== hdl/dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// ----------------------------------------
// Data cache geometry
// ----------------------------------------

// Word width on both CPU and bus side
`define DC_XLEN       32

// 16 sets x 2 ways x 16 bytes = 512 bytes
`define DC_SETS       16
`define DC_WAYS       2

// Words per line, one bus beat each
`define DC_BURST_LEN  4

// ----------------------------------------
// Replacement
// ----------------------------------------

// Random way pick, x^7 + x^6 + 1
`define DC_LFSR_W     7

`endif

// ==== hdl/dcache_pkg.sv ====
`include "dcache_defines.svh"

package dcache_pkg;

  // Address and data words
  typedef logic [`DC_XLEN-1:0]                word_t;
  typedef logic [$clog2(`DC_SETS)-1:0]        idx_t;     // Set index, adr[7:4]
  typedef logic [$clog2(`DC_BURST_LEN)-1:0]   boff_t;    // Word in line, adr[3:2]
  typedef logic [`DC_XLEN - $clog2(`DC_SETS) - $clog2(`DC_BURST_LEN)
                 - $clog2(`DC_XLEN/8) - 1:0]  tag_t;     // Upper address bits
  typedef logic [`DC_BURST_LEN*`DC_XLEN-1:0]  line_t;    // Full cache line
  typedef logic [`DC_WAYS-1:0]                way_sel_t; // One-hot way

  // Front-end FSM
  typedef enum logic [2:0] {
    HIT_IDLE, HIT_LOOKUP, HIT_FILL, HIT_REPLAY, HIT_WRITE, HIT_FLUSH
  } hit_state_e;

  // Bus FSM
  typedef enum logic [1:0] {
    BIU_IDLE, BIU_ADDR, BIU_DATA, BIU_COMMIT
  } biu_state_e;

  // Bus transfer type
  typedef enum logic {
    SINGLE, INCR
  } biu_type_e;

endpackage

// ==== hdl/dcache_setup.sv ====
`timescale 1ns/1ps

module dcache_setup (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              mem_req_i,
  input  logic              mem_we_i,
  input  dcache_pkg::word_t mem_adr_i,
  input  dcache_pkg::word_t mem_d_i,
  input  logic              stall_i,

  output logic              setup_req_o,
  output logic              setup_we_o,
  output dcache_pkg::word_t setup_adr_o,
  output dcache_pkg::word_t setup_d_o,
  output dcache_pkg::idx_t  setup_idx_o
);

  import dcache_pkg::*;

  // Index sits right below the tag
  localparam int unsigned IDX_LSB = $bits(word_t) - $bits(tag_t) - $bits(idx_t);

  // ----------------------------------------
  // Request register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      setup_req_o <= 1'b0;
      setup_we_o  <= 1'b0;
    end else if (!stall_i) begin  // Hold while back end busy
      setup_req_o <= mem_req_i;
      setup_we_o  <= mem_we_i;
    end
  end

  // Address and store data
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      setup_adr_o <= mem_adr_i;
      setup_d_o   <= mem_d_i;
    end
  end

  // Array index runs one cycle ahead of the lookup
  assign setup_idx_o = stall_i ? setup_adr_o[IDX_LSB +: $bits(idx_t)]  // Held request
                               : mem_adr_i[IDX_LSB +: $bits(idx_t)];   // Incoming request

endmodule

// ==== hdl/dcache_memory.sv ====
`timescale 1ns/1ps

`include "dcache_defines.svh"

module dcache_memory (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  dcache_pkg::idx_t  rd_idx_i,
  input  dcache_pkg::word_t cmp_adr_i,
  input  logic              fill_we_i,
  input  dcache_pkg::line_t fill_line_i,
  input  logic              word_we_i,
  input  dcache_pkg::word_t word_d_i,
  input  logic              flush_start_i,

  output logic              hit_o,
  output dcache_pkg::line_t line_o,
  output logic              flush_done_o
);

  import dcache_pkg::*;

  localparam int unsigned IDX_LSB  = $bits(word_t) - $bits(tag_t) - $bits(idx_t);
  localparam int unsigned BOFF_LSB = IDX_LSB - $bits(boff_t);

  tag_t                 tag_mem  [`DC_WAYS][`DC_SETS];
  line_t                data_mem [`DC_WAYS][`DC_SETS];
  logic [`DC_WAYS-1:0]  valid_q  [`DC_SETS];   // One bit per way

  tag_t                 rd_tag_q  [`DC_WAYS];
  line_t                rd_line_q [`DC_WAYS];
  logic [`DC_WAYS-1:0]  rd_valid_q;

  way_sel_t             hit_way;
  way_sel_t             fill_way;
  logic [`DC_LFSR_W-1:0] lfsr_q;
  logic                 flushing_q;
  idx_t                 flush_idx_q;

  tag_t                 cmp_tag;
  idx_t                 wr_idx;
  boff_t                wr_boff;

  assign cmp_tag = cmp_adr_i[$bits(word_t)-1 -: $bits(tag_t)];
  assign wr_idx  = cmp_adr_i[IDX_LSB +: $bits(idx_t)];
  assign wr_boff = cmp_adr_i[BOFF_LSB +: $bits(boff_t)];

  // ----------------------------------------
  // Arrays
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      rd_tag_q[w]  <= tag_mem[w][rd_idx_i];   // Synchronous read
      rd_line_q[w] <= data_mem[w][rd_idx_i];
      if (fill_we_i && fill_way[w]) begin
        tag_mem[w][wr_idx]  <= cmp_tag;
        data_mem[w][wr_idx] <= fill_line_i;
      end else if (word_we_i && hit_way[w]) begin  // Store hit, one word only
        data_mem[w][wr_idx][wr_boff*`DC_XLEN +: `DC_XLEN] <= word_d_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < `DC_SETS; s++) begin
        valid_q[s] <= '0;
      end
      rd_valid_q <= '0;
    end else begin
      rd_valid_q <= valid_q[rd_idx_i];
      if (flushing_q) begin
        valid_q[flush_idx_q] <= '0;                 // Sweep one set per cycle
      end else if (fill_we_i) begin
        valid_q[wr_idx] <= valid_q[wr_idx] | fill_way;
      end
    end
  end

  // Tag compare on the registered read
  always_comb begin
    line_o = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      hit_way[w] = rd_valid_q[w] && (rd_tag_q[w] == cmp_tag);
      line_o     = line_o | (rd_line_q[w] & {$bits(line_t){hit_way[w]}});
    end
  end

  assign hit_o = |hit_way;

  // ----------------------------------------
  // Replacement and flush
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= '0;                                 // XNOR feedback, zero is legal
    end else if (!fill_we_i) begin                  // Frozen while a line is written
      lfsr_q <= {lfsr_q[`DC_LFSR_W-2:0], lfsr_q[`DC_LFSR_W-1] ~^ lfsr_q[`DC_LFSR_W-2]};
    end
  end

  // Free way first, random way once the set is full
  always_comb begin
    fill_way = way_sel_t'(1) << lfsr_q[$clog2(`DC_WAYS)-1:0];
    for (int w = `DC_WAYS - 1; w >= 0; w--) begin
      if (!valid_q[wr_idx][w]) begin
        fill_way = way_sel_t'(1) << w;              // Lowest invalid way
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flushing_q  <= 1'b0;
      flush_idx_q <= '0;
    end else if (flush_start_i) begin
      flushing_q  <= 1'b1;
      flush_idx_q <= '0;
    end else if (flushing_q) begin
      flush_idx_q <= flush_idx_q + idx_t'(1);
      if (flush_done_o) begin
        flushing_q <= 1'b0;
      end
    end
  end

  assign flush_done_o = flushing_q && (flush_idx_q == idx_t'(`DC_SETS - 1));  // Last set

endmodule

// ==== hdl/dcache_hit_ctrl.sv ====
`timescale 1ns/1ps

module dcache_hit_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              setup_req_i,
  input  logic              setup_we_i,
  input  dcache_pkg::word_t setup_adr_i,
  input  dcache_pkg::word_t setup_d_i,
  input  logic              hit_i,
  input  dcache_pkg::line_t line_i,
  input  logic              biu_done_i,
  input  logic              cache_flush_i,
  input  logic              flush_done_i,

  output logic              stall_o,
  output logic              mem_ack_o,
  output dcache_pkg::word_t mem_q_o,
  output logic              fill_req_o,
  output logic              wr_req_o,
  output logic              word_we_o,
  output logic              flush_start_o,
  output logic              cache_flush_rdy_o
);

  import dcache_pkg::*;

  localparam int unsigned BOFF_LSB = $bits(word_t) - $bits(tag_t) - $bits(idx_t)
                                     - $bits(boff_t);

  hit_state_e state_q, state_d;
  logic       resp_q;        // Ack or flush ready in last cycle
  logic       flush_pend_q;
  logic       req_valid;
  boff_t      boff;
  word_t      rd_word;

  // Held request was already answered while resp_q is high
  assign req_valid = setup_req_i && !resp_q;

  // Setup holds its register while anything is in progress
  assign stall_o = (state_q != HIT_IDLE) || req_valid;

  // ----------------------------------------
  // Read data
  // ----------------------------------------
  assign boff    = setup_adr_i[BOFF_LSB +: $bits(boff_t)];
  assign rd_word = line_i[boff*$bits(word_t) +: $bits(word_t)];
  assign mem_q_o = setup_we_i ? setup_d_i : rd_word;  // Stores echo their data

  // ----------------------------------------
  // Front-end FSM
  // ----------------------------------------
  always_comb begin
    state_d           = state_q;
    mem_ack_o         = 1'b0;
    fill_req_o        = 1'b0;
    wr_req_o          = 1'b0;
    word_we_o         = 1'b0;
    flush_start_o     = 1'b0;
    cache_flush_rdy_o = 1'b0;

    unique case (state_q)
      HIT_IDLE: begin
        if (flush_pend_q) begin         // Flush wins, request waits in setup
          flush_start_o = 1'b1;
          state_d       = HIT_FLUSH;
        end else if (req_valid) begin
          state_d = HIT_LOOKUP;
        end
      end
      HIT_LOOKUP: begin
        if (setup_we_i) begin           // Write-through, no allocate
          wr_req_o  = 1'b1;
          word_we_o = hit_i;
          state_d   = HIT_WRITE;
        end else if (hit_i) begin
          mem_ack_o = 1'b1;
          state_d   = HIT_IDLE;
        end else begin
          fill_req_o = 1'b1;
          state_d    = HIT_FILL;
        end
      end
      HIT_FILL: begin
        if (biu_done_i) begin
          state_d = HIT_REPLAY;         // Line now in the array
        end
      end
      HIT_REPLAY: begin
        mem_ack_o = 1'b1;               // Answer from the re-read line
        state_d   = HIT_IDLE;
      end
      HIT_WRITE: begin
        if (biu_done_i) begin
          mem_ack_o = 1'b1;
          state_d   = HIT_IDLE;
        end
      end
      HIT_FLUSH: begin
        if (flush_done_i) begin
          cache_flush_rdy_o = 1'b1;
          state_d           = HIT_IDLE;
        end
      end
      default: state_d = HIT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= HIT_IDLE;
      resp_q       <= 1'b0;
      flush_pend_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      resp_q       <= mem_ack_o || cache_flush_rdy_o;
      // Pending until sweep ends, held request ignored right after
      flush_pend_q <= (flush_pend_q || (cache_flush_i && !resp_q)) && !cache_flush_rdy_o;
    end
  end

endmodule

// ==== hdl/dcache_biu_ctrl.sv ====
`timescale 1ns/1ps

`include "dcache_defines.svh"

module dcache_biu_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  fill_req_i,
  input  logic                  wr_req_i,
  input  dcache_pkg::word_t     adr_i,
  input  dcache_pkg::word_t     d_i,
  input  logic                  biu_stb_ack_i,
  input  logic                  biu_ack_i,
  input  dcache_pkg::word_t     biu_q_i,

  output logic                  done_o,
  output logic                  fill_we_o,
  output dcache_pkg::line_t     fill_line_o,
  output logic                  biu_stb_o,
  output dcache_pkg::word_t     biu_adri_o,
  output dcache_pkg::biu_type_e biu_type_o,
  output logic                  biu_we_o,
  output dcache_pkg::word_t     biu_d_o
);

  import dcache_pkg::*;

  // Byte offset inside a line
  localparam int unsigned LINE_LSB = $bits(word_t) - $bits(tag_t) - $bits(idx_t);

  biu_state_e state_q, state_d;
  boff_t      beat_q;
  logic       done_q;
  word_t      adr_q;
  word_t      d_q;
  logic       we_q;
  biu_type_e  type_q;
  line_t      line_q;     // Line buffer
  logic       beat_en;
  logic       last_beat;

  // Data may come back with the strobe ack
  assign beat_en   = biu_ack_i && ((state_q == BIU_DATA) ||
                                   (state_q == BIU_ADDR && biu_stb_ack_i));
  assign last_beat = (type_q == SINGLE) || (beat_q == boff_t'(`DC_BURST_LEN - 1));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      BIU_IDLE:   if (fill_req_i || wr_req_i) state_d = BIU_ADDR;
      BIU_ADDR:   if (beat_en && last_beat) state_d = BIU_COMMIT;
                  else if (biu_stb_ack_i)   state_d = BIU_DATA;
      BIU_DATA:   if (beat_en && last_beat) state_d = BIU_COMMIT;
      BIU_COMMIT: state_d = BIU_IDLE;
      default:    state_d = BIU_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= BIU_IDLE;
      beat_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= (state_q == BIU_COMMIT);   // One cycle after the array write
      if (state_q == BIU_IDLE) beat_q <= '0;
      else if (beat_en)        beat_q <= beat_q + boff_t'(1);
    end
  end

  // ----------------------------------------
  // Transfer registers and line buffer
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (state_q == BIU_IDLE) begin
      if (fill_req_i) begin                 // Burst from line start
        adr_q  <= {adr_i[$bits(word_t)-1:LINE_LSB], {LINE_LSB{1'b0}}};
        we_q   <= 1'b0;
        type_q <= INCR;
      end else if (wr_req_i) begin
        adr_q  <= adr_i;
        d_q    <= d_i;
        we_q   <= 1'b1;
        type_q <= SINGLE;
      end
    end
    if (beat_en) line_q[beat_q*$bits(word_t) +: $bits(word_t)] <= biu_q_i;
  end

  assign done_o      = done_q;
  assign fill_we_o   = (state_q == BIU_COMMIT) && !we_q;  // Fills only
  assign fill_line_o = line_q;

  assign biu_stb_o   = (state_q == BIU_ADDR);
  assign biu_adri_o  = adr_q;
  assign biu_type_o  = type_q;
  assign biu_we_o    = we_q;
  assign biu_d_o     = d_q;

endmodule

// ==== hdl/dcache_core.sv ====
`timescale 1ns/1ps

module dcache_core (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // CPU side
  input  logic                  mem_req_i,
  input  logic                  mem_we_i,
  input  dcache_pkg::word_t     mem_adr_i,
  input  dcache_pkg::word_t     mem_d_i,
  output logic                  mem_ack_o,
  output dcache_pkg::word_t     mem_q_o,
  input  logic                  cache_flush_i,     // Invalidate all lines
  output logic                  cache_flush_rdy_o,

  // Bus side
  output logic                  biu_stb_o,
  input  logic                  biu_stb_ack_i,
  output dcache_pkg::word_t     biu_adri_o,
  output dcache_pkg::biu_type_e biu_type_o,
  output logic                  biu_we_o,
  output dcache_pkg::word_t     biu_d_o,
  input  dcache_pkg::word_t     biu_q_i,
  input  logic                  biu_ack_i
);

  import dcache_pkg::*;

  logic  stall;
  logic  setup_req, setup_we;
  word_t setup_adr, setup_d;
  idx_t  setup_idx;
  logic  hit;
  line_t line;
  logic  fill_req, wr_req, word_we;
  logic  flush_start, flush_done;
  logic  biu_done, fill_we;
  line_t fill_line;

  // ----------------------------------------
  // Request register
  // ----------------------------------------
  dcache_setup setup_inst (
    .clk_i       (clk_i),     .rst_ni      (rst_ni),
    .mem_req_i   (mem_req_i), .mem_we_i    (mem_we_i),
    .mem_adr_i   (mem_adr_i), .mem_d_i     (mem_d_i),
    .stall_i     (stall),
    .setup_req_o (setup_req), .setup_we_o  (setup_we),
    .setup_adr_o (setup_adr), .setup_d_o   (setup_d),
    .setup_idx_o (setup_idx)
  );

  // Tag, valid and data arrays
  dcache_memory memory_inst (
    .clk_i         (clk_i),       .rst_ni        (rst_ni),
    .rd_idx_i      (setup_idx),   .cmp_adr_i     (setup_adr),
    .fill_we_i     (fill_we),     .fill_line_i   (fill_line),
    .word_we_i     (word_we),     .word_d_i      (setup_d),
    .flush_start_i (flush_start),
    .hit_o         (hit),         .line_o        (line),
    .flush_done_o  (flush_done)
  );

  // ----------------------------------------
  // Control
  // ----------------------------------------
  dcache_hit_ctrl hit_ctrl_inst (
    .clk_i             (clk_i),         .rst_ni            (rst_ni),
    .setup_req_i       (setup_req),     .setup_we_i        (setup_we),
    .setup_adr_i       (setup_adr),     .setup_d_i         (setup_d),
    .hit_i             (hit),           .line_i            (line),
    .biu_done_i        (biu_done),      .cache_flush_i     (cache_flush_i),
    .flush_done_i      (flush_done),
    .stall_o           (stall),         .mem_ack_o         (mem_ack_o),
    .mem_q_o           (mem_q_o),
    .fill_req_o        (fill_req),      .wr_req_o          (wr_req),
    .word_we_o         (word_we),       .flush_start_o     (flush_start),
    .cache_flush_rdy_o (cache_flush_rdy_o)
  );

  // Address comes from the held setup register
  dcache_biu_ctrl biu_ctrl_inst (
    .clk_i         (clk_i),         .rst_ni        (rst_ni),
    .fill_req_i    (fill_req),      .wr_req_i      (wr_req),
    .adr_i         (setup_adr),     .d_i           (setup_d),
    .biu_stb_ack_i (biu_stb_ack_i), .biu_ack_i     (biu_ack_i),
    .biu_q_i       (biu_q_i),
    .done_o        (biu_done),      .fill_we_o     (fill_we),
    .fill_line_o   (fill_line),
    .biu_stb_o     (biu_stb_o),     .biu_adri_o    (biu_adri_o),
    .biu_type_o    (biu_type_o),    .biu_we_o      (biu_we_o),
    .biu_d_o       (biu_d_o)
  );

endmodule

// ==== sim/tb_bus_model.sv ====
`timescale 1ns/1ps

`include "dcache_defines.svh"

module tb_bus_model (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  biu_stb_i,
  input  dcache_pkg::word_t     biu_adri_i,
  input  dcache_pkg::biu_type_e biu_type_i,
  input  logic                  biu_we_i,
  input  dcache_pkg::word_t     biu_d_i,

  output logic                  biu_stb_ack_o,
  output logic                  biu_ack_o,
  output dcache_pkg::word_t     biu_q_o
);

  import dcache_pkg::*;

  word_t mem [word_t];     // Only written words are stored
  word_t lcg_q;

  function automatic word_t lcg_next(input word_t s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Untouched words follow the address pattern
  function automatic word_t read_word(input word_t adr);
    if (mem.exists(adr)) return mem[adr];
    return adr ^ 32'h5a5a0000;
  endfunction

  task automatic next_delay(output int d);
    lcg_q = lcg_next(lcg_q);
    d     = int'(lcg_q[17:16]);   // 0 to 3 cycles
  endtask

  // Edge, then a small hold delay
  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // ----------------------------------------
  // One transfer at a time
  // ----------------------------------------
  initial begin
    int    d;
    int    beats;
    word_t adr;
    word_t wd;
    logic  we;

    biu_stb_ack_o = 1'b0;
    biu_ack_o     = 1'b0;
    biu_q_o       = '0;
    lcg_q         = 32'h30be;
    forever begin
      @(posedge clk_i);
      #1;
      if (rst_ni && biu_stb_i) begin
        adr   = biu_adri_i;
        we    = biu_we_i;
        wd    = biu_d_i;
        beats = (biu_type_i == INCR) ? `DC_BURST_LEN : 1;
        next_delay(d);
        wait_cycles(d);
        biu_stb_ack_o = 1'b1;         // Address phase done
        wait_cycles(1);
        biu_stb_ack_o = 1'b0;
        for (int b = 0; b < beats; b++) begin
          next_delay(d);
          wait_cycles(d);
          biu_ack_o = 1'b1;
          biu_q_o   = read_word(adr + word_t'(4 * b));
          if (we) mem[adr] = wd;      // Single write lands here
          wait_cycles(1);
          biu_ack_o = 1'b0;
        end
      end
    end
  end

endmodule

// ==== sim/tb_dcache_core.sv ====
`timescale 1ns/1ps

module tb_dcache_core;

  import dcache_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int CYCLES_PER_LINE = 60;
  localparam int HIT_LATENCY     = 2;   // Negedges after the setup edge
  localparam int NO_CHECK        = 2;   // Fill flag not compared

  logic      clk_i, rst_ni;
  logic      mem_req_i, mem_we_i, mem_ack_o;
  word_t     mem_adr_i, mem_d_i, mem_q_o;
  logic      cache_flush_i, cache_flush_rdy_o;
  logic      biu_stb_o, biu_stb_ack_i, biu_we_o, biu_ack_i;
  word_t     biu_adri_o, biu_d_o, biu_q_i;
  biu_type_e biu_type_o;

  string op_q[$];
  word_t adr_q[$], wd_q[$], exp_q[$];
  int    fill_q[$];
  int    n_lines  = 0;
  int    incr_cnt = 0;

  dcache_core dut_i (
    .clk_i, .rst_ni, .mem_req_i, .mem_we_i, .mem_adr_i, .mem_d_i, .mem_ack_o, .mem_q_o,
    .cache_flush_i, .cache_flush_rdy_o, .biu_stb_o, .biu_stb_ack_i, .biu_adri_o,
    .biu_type_o, .biu_we_o, .biu_d_o, .biu_q_i, .biu_ack_i
  );

  tb_bus_model bus_i (
    .clk_i, .rst_ni, .biu_stb_i (biu_stb_o), .biu_adri_i (biu_adri_o),
    .biu_type_i (biu_type_o), .biu_we_i (biu_we_o), .biu_d_i (biu_d_o),
    .biu_stb_ack_o (biu_stb_ack_i), .biu_ack_o (biu_ack_i), .biu_q_o (biu_q_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Accepted burst strobes, sampled mid-cycle
  always @(negedge clk_i) begin
    if (biu_stb_o && biu_stb_ack_i && biu_type_o == INCR) incr_cnt++;
  end

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // ----------------------------------------
  // Golden file
  // ----------------------------------------
  task automatic load_golden();
    int    fd;
    int    n;
    int    f;
    string line;
    string op;
    word_t a, w, e;

    fd = $fopen("sim/dcache_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open sim/dcache_golden.txt");
      $display("tests failed");
      $fatal(1, "no stimulus");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line.substr(0, 0) != "#") begin   // Skip blanks and comments
        if ($sscanf(line, "%s %h %h %h %d", op, a, w, e, f) == 5) begin
          op_q.push_back(op);
          adr_q.push_back(a);
          wd_q.push_back(w);
          exp_q.push_back(e);
          fill_q.push_back(f);
        end
      end
    end
    $fclose(fd);
    if (op_q.size() == 0) begin
      $display("golden file holds no accesses");
      $display("tests failed");
      $fatal(1, "no stimulus");
    end
    n_lines = op_q.size();
  endtask

  task automatic run_access(input int i);
    int start_fill;
    int cyc;

    start_fill = incr_cnt;
    cyc        = 0;
    @(posedge clk_i);
    #1;
    if (op_q[i] == "f") begin
      cache_flush_i = 1'b1;
      do @(negedge clk_i); while (!cache_flush_rdy_o);
    end else begin
      mem_req_i = 1'b1;
      mem_we_i  = (op_q[i] == "w");
      mem_adr_i = adr_q[i];
      mem_d_i   = wd_q[i];
      @(posedge clk_i);              // Setup samples here
      do begin
        @(negedge clk_i);
        cyc++;
      end while (!mem_ack_o);
      check_value("mem_q_o", mem_q_o, exp_q[i]);
    end
    @(posedge clk_i);
    #1;
    mem_req_i     = 1'b0;
    cache_flush_i = 1'b0;
    if (fill_q[i] != NO_CHECK)
      check_value("fill_flag", word_t'(incr_cnt != start_fill), word_t'(fill_q[i]));
    if (op_q[i] == "r" && fill_q[i] == 0) check_value("hit_latency", word_t'(cyc),
                                                      word_t'(HIT_LATENCY));
  endtask

  // ----------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------
  initial begin
    rst_ni        = 1'b0;
    mem_req_i     = 1'b0;
    mem_we_i      = 1'b0;
    mem_adr_i     = '0;
    mem_d_i       = '0;
    cache_flush_i = 1'b0;
    load_golden();
    repeat (10) @(posedge clk_i);
    #1;
    // Quiet outputs while held in reset
    check_value("mem_ack_o", word_t'(mem_ack_o), word_t'(0));
    check_value("biu_stb_o", word_t'(biu_stb_o), word_t'(0));
    check_value("cache_flush_rdy_o", word_t'(cache_flush_rdy_o), word_t'(0));
    rst_ni = 1'b1;
    for (int i = 0; i < n_lines; i++) run_access(i);
    repeat (2) @(posedge clk_i);
    $display("all tests passed");
    $finish;
  end

  initial begin
    wait (n_lines > 0);
    #(n_lines * CYCLES_PER_LINE * CLK_PERIOD);
    $display("cache stopped responding within %0d cycles", n_lines * CYCLES_PER_LINE);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== sim/dcache_golden.txt ====
# op (r read, w write, f flush), address, write data, expected read data (hex)
# last column is the fill flag: 1 fill, 0 no fill, 2 not checked
r 00001000 00000000 5a5a1000 1
r 00001004 00000000 5a5a1004 0
r 0000100c 00000000 5a5a100c 0
r 00001008 00000000 5a5a1008 0
r 00002010 00000000 5a5a2010 1
r 00002014 00000000 5a5a2014 0
r 00003000 00000000 5a5a3000 1
r 00001004 00000000 5a5a1004 0
r 00003008 00000000 5a5a3008 0
r 00001000 00000000 5a5a1000 0
w 00001008 deadbeef deadbeef 0
r 00001008 00000000 deadbeef 0
r 0000100c 00000000 5a5a100c 0
w 00004020 cafef00d cafef00d 0
r 00004020 00000000 cafef00d 1
r 00004024 00000000 5a5a4024 0
r 12345630 00000000 486e5630 1
w 12345634 01234567 01234567 0
r 12345634 00000000 01234567 0
r 1234563c 00000000 486e563c 0
f 00000000 00000000 00000000 0
r 00001000 00000000 5a5a1000 1
r 00001008 00000000 deadbeef 0
r 00003000 00000000 5a5a3000 1
r 00002014 00000000 5a5a2014 1
r 00004020 00000000 cafef00d 1
r 12345634 00000000 01234567 1
r 00006040 00000000 5a5a6040 1
r 0000604c 00000000 5a5a604c 0
r 00005000 00000000 5a5a5000 2
r 00001004 00000000 5a5a1004 2
r 00003004 00000000 5a5a3004 2
r 00005008 00000000 5a5a5008 2
r 00001008 00000000 deadbeef 2

// ==== list.f ====
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_setup.sv
hdl/dcache_memory.sv
hdl/dcache_hit_ctrl.sv
hdl/dcache_biu_ctrl.sv
hdl/dcache_core.sv
sim/tb_bus_model.sv
sim/tb_dcache_core.sv

// ==== Makefile ====
TOP = tb_dcache_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)
	verilator --lint-only -f list.f --top-module dcache_core

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
